/* src/io_pkg.sv */
package io_pkg;

	localparam int io_addr_w = 16;

	// device groups seen by the port decoder.
	typedef enum logic [3:0] {
		none     = 4'd0,
		ide0     = 4'd1,
		ide1     = 4'd2,
		floppy   = 4'd3,
		dma      = 4'd4, // master, slave and page registers.
		pic      = 4'd5, // master and slave.
		pit      = 4'd6,
		ps2      = 4'd7,
		rtc      = 4'd8,
		sound    = 4'd9, // fm and sb.
		uart1    = 4'd10,
		uart2    = 4'd11,
		mpu      = 4'd12,
		vga      = 4'd13,
		joystick = 4'd14,
		sysctl   = 4'd15
	} io_dev_t;

	// write word, plain data or the keyed form used by the sysctl port.
	typedef union packed {
		logic [31:0] raw;
		struct packed {
			logic [15:0] unused;
			logic [7:0]  key;
			logic [7:0]  value;
		} kv;
	} io_word_t;

	localparam logic [io_addr_w-1:0] port_ide0        = 16'h01F0;
	localparam logic [io_addr_w-1:0] port_ide0_ctl    = 16'h03F6;
	localparam logic [io_addr_w-1:0] port_ide1        = 16'h0170;
	localparam logic [io_addr_w-1:0] port_ide1_ctl    = 16'h0376;
	localparam logic [io_addr_w-1:0] port_floppy      = 16'h03F0;
	localparam logic [io_addr_w-1:0] port_floppy_data = 16'h03F4;
	localparam logic [io_addr_w-1:0] port_floppy_dir  = 16'h03F7;
	localparam logic [io_addr_w-1:0] port_dma_master  = 16'h00C0;
	localparam logic [io_addr_w-1:0] port_dma_page    = 16'h0080;
	localparam logic [io_addr_w-1:0] port_dma_slave   = 16'h0000;
	localparam logic [io_addr_w-1:0] port_pic_master  = 16'h0020;
	localparam logic [io_addr_w-1:0] port_pic_slave   = 16'h00A0;
	localparam logic [io_addr_w-1:0] port_pit         = 16'h0040;
	localparam logic [io_addr_w-1:0] port_pit_b       = 16'h0061;
	localparam logic [io_addr_w-1:0] port_ps2_io      = 16'h0060;
	localparam logic [io_addr_w-1:0] port_ps2_ctl     = 16'h0090;
	localparam logic [io_addr_w-1:0] port_rtc         = 16'h0070;
	localparam logic [io_addr_w-1:0] port_fm          = 16'h0388;
	localparam logic [io_addr_w-1:0] port_sb          = 16'h0220;
	localparam logic [io_addr_w-1:0] port_uart1       = 16'h03F8;
	localparam logic [io_addr_w-1:0] port_uart2       = 16'h02F8;
	localparam logic [io_addr_w-1:0] port_mpu         = 16'h0330;
	localparam logic [io_addr_w-1:0] port_vga_b       = 16'h03B0;
	localparam logic [io_addr_w-1:0] port_vga_c       = 16'h03C0;
	localparam logic [io_addr_w-1:0] port_vga_d       = 16'h03D0;
	localparam logic [io_addr_w-1:0] port_joystick    = 16'h0201;
	localparam logic [io_addr_w-1:0] port_sysctl      = 16'h8888;

	// datasize code of a 16-bit access.
	localparam logic [2:0] io_size_word = 3'd2;

endpackage

/* src/port_decode.sv */
module port_decode
	import io_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 reset,

	input  logic [io_addr_w-1:0] io_address,
	input  logic                 io_read,
	input  logic                 io_write,
	input  logic [2:0]           io_datasize,
	input  io_word_t             io_writedata,

	output io_dev_t              dec_dev,
	output logic [io_addr_w-1:0] dec_address,
	output logic                 dec_read,
	output logic                 dec_write,
	output logic [2:0]           dec_datasize,
	output io_word_t             dec_writedata
);

	io_dev_t dev_next;

	// address falls in the range at base, ignoring the low bits.
	function automatic logic hit(
		input logic [io_addr_w-1:0] addr,
		input logic [io_addr_w-1:0] base,
		input int unsigned          low
	);
		logic [io_addr_w-1:0] mask;
		mask = {io_addr_w{1'b1}} << low;
		return (addr & mask) == (base & mask);
	endfunction

	always_comb begin
		dev_next = none;
		if (hit(io_address, port_ide0, 3) || hit(io_address, port_ide0_ctl, 0))
			dev_next = ide0;
		else if (hit(io_address, port_ide1, 3) || hit(io_address, port_ide1_ctl, 0))
			dev_next = ide1;
		else if (hit(io_address, port_floppy, 2) || hit(io_address, port_floppy_data, 1) ||
				hit(io_address, port_floppy_dir, 0))
			dev_next = floppy;
		else if (hit(io_address, port_dma_master, 5) || hit(io_address, port_dma_page, 4) ||
				hit(io_address, port_dma_slave, 4))
			dev_next = dma;
		else if (hit(io_address, port_pic_master, 1) || hit(io_address, port_pic_slave, 1))
			dev_next = pic;
		else if (hit(io_address, port_pit, 2) || hit(io_address, port_pit_b, 0))
			dev_next = pit; // 61h is port b, speaker gate lives there.
		else if (hit(io_address, port_ps2_io, 3) || hit(io_address, port_ps2_ctl, 4))
			dev_next = ps2;
		else if (hit(io_address, port_rtc, 1))
			dev_next = rtc;
		else if (hit(io_address, port_fm, 2) || hit(io_address, port_sb, 4))
			dev_next = sound;
		else if (hit(io_address, port_uart1, 3))
			dev_next = uart1;
		else if (hit(io_address, port_uart2, 3))
			dev_next = uart2;
		else if (hit(io_address, port_mpu, 1))
			dev_next = mpu;
		else if (hit(io_address, port_vga_b, 4) || hit(io_address, port_vga_c, 4) ||
				hit(io_address, port_vga_d, 4))
			dev_next = vga;
		else if (hit(io_address, port_joystick, 0))
			dev_next = joystick;
		else if (hit(io_address, port_sysctl, 0))
			dev_next = sysctl;
	end

	// select and strobes move together.
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dec_dev   <= none;
			dec_read  <= 1'b0;
			dec_write <= 1'b0;
		end else begin
			dec_dev   <= dev_next;
			dec_read  <= io_read;
			dec_write <= io_write;
		end
	end

	always_ff @(posedge clk_sys) begin
		dec_address       <= io_address;
		dec_datasize      <= io_datasize;
		dec_writedata.raw <= io_writedata.raw;
	end

endmodule

/* src/read_return.sv */
module read_return
	import io_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 reset,

	input  io_dev_t              dec_dev,
	input  logic [io_addr_w-1:0] dec_address,

	input  logic [7:0]           floppy_readdata,
	input  logic [7:0]           dma_readdata,
	input  logic [7:0]           pic_readdata,
	input  logic [7:0]           pit_readdata,
	input  logic [7:0]           ps2_readdata,
	input  logic [7:0]           rtc_readdata,
	input  logic [7:0]           sound_readdata,
	input  logic [7:0]           uart1_readdata,
	input  logic [7:0]           uart2_readdata,
	input  logic [7:0]           mpu_readdata,
	input  logic [7:0]           vga_readdata,
	input  logic [7:0]           joystick_readdata,
	input  logic [31:0]          ide0_readdata,
	input  logic [31:0]          ide1_readdata,

	output logic [31:0]          io_readdata,
	output logic                 io_io32
);

	logic [7:0]  byte_data;
	logic [31:0] read_next;
	logic        io32_next;

	always_comb begin
		case (dec_dev)
			floppy:   byte_data = floppy_readdata;
			dma:      byte_data = dma_readdata;
			pic:      byte_data = pic_readdata;
			pit:      byte_data = pit_readdata;
			ps2:      byte_data = ps2_readdata;
			rtc:      byte_data = rtc_readdata;
			sound:    byte_data = sound_readdata;
			uart1:    byte_data = uart1_readdata;
			uart2:    byte_data = uart2_readdata;
			mpu:      byte_data = mpu_readdata;
			vga:      byte_data = vga_readdata;
			joystick: byte_data = joystick_readdata;
			default:  byte_data = 8'hFF; // floating bus.
		endcase
	end

	always_comb begin
		if (dec_dev == ide0)
			read_next = ide0_readdata;
		else if (dec_dev == ide1)
			read_next = ide1_readdata;
		else
			read_next = {24'd0, byte_data};
	end

	// 32-bit path only for the ide data block, not the control ports at 3x6h.
	assign io32_next = ((dec_dev == ide0 || dec_dev == ide1) && !dec_address[9]) ||
		(dec_dev == sysctl);

	always_ff @(posedge clk_sys) begin
		if (reset)
			io_io32 <= 1'b0;
		else
			io_io32 <= io32_next;
	end

	always_ff @(posedge clk_sys) begin
		io_readdata <= read_next;
	end

endmodule

/* src/ide_read_hold.sv */
module ide_read_hold
	import io_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 reset,

	input  io_dev_t              dec_dev,
	input  logic [io_addr_w-1:0] dec_address,
	input  logic                 dec_read,
	input  logic                 ide0_nodata,
	input  logic                 ide1_nodata,

	output logic                 ide0_read,
	output logic                 ide1_read,
	output logic                 io_wait
);

	logic [1:0] sel;
	logic [1:0] nodata;
	logic [1:0] hold;
	logic       data_port;

	assign sel       = {dec_dev == ide1, dec_dev == ide0};
	assign nodata    = {ide1_nodata, ide0_nodata};
	assign data_port = !dec_address[9] && (dec_address[2:0] == 3'd0); // 1F0h / 170h.

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hold <= 2'b00;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (dec_read && sel[i] && data_port && nodata[i])
					hold[i] <= 1'b1;
				if (!nodata[i])
					hold[i] <= 1'b0; // drive has data again.
			end
		end
	end

	assign ide0_read = (dec_read && sel[0]) || hold[0];
	assign ide1_read = (dec_read && sel[1]) || hold[1];
	assign io_wait   = |hold;

endmodule

/* src/sysctl_port.sv */
module sysctl_port
	import io_pkg::*;
#(
	parameter logic [7:0] SYSCFG_DEFAULT = 8'hA2,
	parameter logic [7:0] SYSCTL_KEY     = 8'hA1
)
(
	input  logic       clk_sys,
	input  logic       reset,

	input  io_dev_t    dec_dev,
	input  logic       dec_write,
	input  logic [2:0] dec_datasize,
	input  io_word_t   dec_writedata,

	output logic [7:0] syscfg
);

	logic after_reset;
	logic disk_access;
	logic key_write;

	assign disk_access = (dec_dev == ide0) || (dec_dev == ide1) || (dec_dev == floppy);

	// only a word write with the right key is taken.
	assign key_write = dec_write && (dec_dev == sysctl) &&
		(dec_datasize == io_size_word) && (dec_writedata.kv.key == SYSCTL_KEY);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			syscfg      <= SYSCFG_DEFAULT;
			after_reset <= 1'b1;
		end else if (after_reset && disk_access) begin
			// boot has reached the disks, drop the power-on setting.
			syscfg      <= 8'd0;
			after_reset <= 1'b0;
		end else if (key_write) begin
			syscfg      <= dec_writedata.kv.value;
			after_reset <= 1'b0;
		end
	end

endmodule

/* src/system_io.sv */
module system_io
	import io_pkg::*;
#(
	parameter logic [7:0] SYSCFG_DEFAULT = 8'hA2,
	parameter logic [7:0] SYSCTL_KEY     = 8'hA1
)
(
	input  logic                 clk_sys,
	input  logic                 reset,

	input  logic [io_addr_w-1:0] io_address,
	input  logic                 io_read,
	input  logic                 io_write,
	input  logic [2:0]           io_datasize,
	input  io_word_t             io_writedata,
	output logic [31:0]          io_readdata,
	output logic                 io_io32,
	output logic                 io_wait,

	output io_dev_t              dev_sel,
	output logic [io_addr_w-1:0] dev_address,
	output logic                 dev_read,
	output logic                 dev_write,
	output io_word_t             dev_writedata,

	input  logic [7:0]           floppy_readdata,
	input  logic [7:0]           dma_readdata,
	input  logic [7:0]           pic_readdata,
	input  logic [7:0]           pit_readdata,
	input  logic [7:0]           ps2_readdata,
	input  logic [7:0]           rtc_readdata,
	input  logic [7:0]           sound_readdata,
	input  logic [7:0]           uart1_readdata,
	input  logic [7:0]           uart2_readdata,
	input  logic [7:0]           mpu_readdata,
	input  logic [7:0]           vga_readdata,
	input  logic [7:0]           joystick_readdata,

	input  logic [31:0]          ide0_readdata,
	input  logic [31:0]          ide1_readdata,
	input  logic                 ide0_nodata,
	input  logic                 ide1_nodata,
	output logic                 ide0_read,
	output logic                 ide1_read,

	output logic [7:0]           syscfg
);

	logic [2:0] dec_datasize;

	port_decode u_decode (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.io_address    (io_address),
		.io_read       (io_read),
		.io_write      (io_write),
		.io_datasize   (io_datasize),
		.io_writedata  (io_writedata),
		.dec_dev       (dev_sel),
		.dec_address   (dev_address),
		.dec_read      (dev_read),
		.dec_write     (dev_write),
		.dec_datasize  (dec_datasize),
		.dec_writedata (dev_writedata)
	);

	read_return u_read_return (
		.clk_sys           (clk_sys),
		.reset             (reset),
		.dec_dev           (dev_sel),
		.dec_address       (dev_address),
		.floppy_readdata   (floppy_readdata),
		.dma_readdata      (dma_readdata),
		.pic_readdata      (pic_readdata),
		.pit_readdata      (pit_readdata),
		.ps2_readdata      (ps2_readdata),
		.rtc_readdata      (rtc_readdata),
		.sound_readdata    (sound_readdata),
		.uart1_readdata    (uart1_readdata),
		.uart2_readdata    (uart2_readdata),
		.mpu_readdata      (mpu_readdata),
		.vga_readdata      (vga_readdata),
		.joystick_readdata (joystick_readdata),
		.ide0_readdata     (ide0_readdata),
		.ide1_readdata     (ide1_readdata),
		.io_readdata       (io_readdata),
		.io_io32           (io_io32)
	);

	ide_read_hold u_ide_hold (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dec_dev     (dev_sel),
		.dec_address (dev_address),
		.dec_read    (dev_read),
		.ide0_nodata (ide0_nodata),
		.ide1_nodata (ide1_nodata),
		.ide0_read   (ide0_read),
		.ide1_read   (ide1_read),
		.io_wait     (io_wait)
	);

	sysctl_port #(
		.SYSCFG_DEFAULT (SYSCFG_DEFAULT),
		.SYSCTL_KEY     (SYSCTL_KEY)
	) u_sysctl (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dec_dev       (dev_sel),
		.dec_write     (dev_write),
		.dec_datasize  (dec_datasize),
		.dec_writedata (dev_writedata),
		.syscfg        (syscfg)
	);

endmodule

/* tests/system_io_sva.sv */
module system_io_sva
	import io_pkg::*;
#(
	parameter logic [7:0] SYSCTL_KEY = 8'hA1
)
(
	input logic                 clk_sys,
	input logic                 reset,
	input io_dev_t              dev_sel,
	input logic [io_addr_w-1:0] dev_address,
	input logic                 dev_read,
	input logic                 dev_write,
	input logic [2:0]           dec_datasize,
	input io_word_t             dev_writedata,
	input logic                 ide0_nodata,
	input logic                 ide1_nodata,
	input logic                 io_wait,
	input logic [7:0]           syscfg
);
	timeunit 1ns;
	timeprecision 100ps;

	logic stall_read;
	logic disk_access;
	logic key_write;

	// data port read on a channel whose drive has nothing yet.
	assign stall_read = dev_read && !dev_address[9] && (dev_address[2:0] == 3'd0) &&
		((dev_sel == ide0 && ide0_nodata) || (dev_sel == ide1 && ide1_nodata));
	assign disk_access = (dev_sel == ide0) || (dev_sel == ide1) || (dev_sel == floppy);
	assign key_write = dev_write && (dev_sel == sysctl) && (dec_datasize == io_size_word) &&
		(dev_writedata.kv.key == SYSCTL_KEY);

	wait_cause: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(io_wait) |-> $past(stall_read))
		else $error("io_wait rose without a stalled ide data read");

	cfg_cause: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(syscfg) |-> $past(reset) || $past(disk_access) || $past(key_write))
		else $error("syscfg changed without a cause");

	rd_wr_excl: assert property (@(posedge clk_sys) disable iff (reset)
		!(dev_read && dev_write))
		else $error("dev_read and dev_write high together");

endmodule

bind system_io system_io_sva #(.SYSCTL_KEY(SYSCTL_KEY)) u_sva (.*);

/* tests/tb_system_io.sv */
module tb_system_io
	import io_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int wait_limit = 32;

	logic                 clk_sys = 1'b0;
	logic                 reset;
	logic [io_addr_w-1:0] io_address;
	logic                 io_read;
	logic                 io_write;
	logic [2:0]           io_datasize;
	io_word_t             io_writedata;
	logic [31:0]          io_readdata;
	logic                 io_io32;
	logic                 io_wait;
	io_dev_t              dev_sel;
	logic [io_addr_w-1:0] dev_address;
	logic                 dev_read;
	logic                 dev_write;
	io_word_t             dev_writedata;
	logic [7:0]           floppy_readdata, dma_readdata, pic_readdata, pit_readdata;
	logic [7:0]           ps2_readdata, rtc_readdata, sound_readdata, uart1_readdata;
	logic [7:0]           uart2_readdata, mpu_readdata, vga_readdata, joystick_readdata;
	logic [31:0]          ide0_readdata;
	logic [31:0]          ide1_readdata;
	logic                 ide0_nodata;
	logic                 ide1_nodata;
	logic                 ide0_read;
	logic                 ide1_read;
	logic [7:0]           syscfg;

	int   errors  = 0;
	int   checks  = 0;
	logic aborted = 1'b0;

	// each device answers 10h plus its own code.
	assign floppy_readdata   = 8'h10 + 8'(floppy);
	assign dma_readdata      = 8'h10 + 8'(dma);
	assign pic_readdata      = 8'h10 + 8'(pic);
	assign pit_readdata      = 8'h10 + 8'(pit);
	assign ps2_readdata      = 8'h10 + 8'(ps2);
	assign rtc_readdata      = 8'h10 + 8'(rtc);
	assign sound_readdata    = 8'h10 + 8'(sound);
	assign uart1_readdata    = 8'h10 + 8'(uart1);
	assign uart2_readdata    = 8'h10 + 8'(uart2);
	assign mpu_readdata      = 8'h10 + 8'(mpu);
	assign vga_readdata      = 8'h10 + 8'(vga);
	assign joystick_readdata = 8'h10 + 8'(joystick);
	assign ide0_readdata     = 32'hA0B1_C2D3;
	assign ide1_readdata     = 32'h5E6F_7081;

	always #20 clk_sys = ~clk_sys;

	system_io #(.SYSCFG_DEFAULT(8'hA2), .SYSCTL_KEY(8'hA1)) DUT (.*);

	task automatic next_edge();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic check_hex(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic wait_for_wait(input logic level);
		int n;
		n = 0;
		while (io_wait !== level && n < wait_limit) begin
			next_edge();
			n++;
		end
		if (io_wait !== level) begin
			errors++;
			aborted = 1'b1;
			$display("timeout: io_wait did not reach %b within %0d cycles", level, wait_limit);
		end
	endtask

	task automatic run_op(input string op, input logic [15:0] addr, input logic [2:0] size,
		input logic [31:0] wdata, input logic [3:0] exp_dev, input logic [31:0] exp_rdata,
		input logic exp_io32, input logic [7:0] exp_cfg);
		logic is_read;
		if (op == "ns" || op == "nc") begin
			if (addr[0])
				ide1_nodata = (op == "ns");
			else
				ide0_nodata = (op == "ns");
			if (op == "nc")
				wait_for_wait(1'b0);
			io_read = 1'b0; // bus lets go of a held read.
			next_edge();
		end else if (op == "id") begin
			io_address = addr;
			io_read    = 1'b0;
			io_write   = 1'b0;
			next_edge();
			next_edge();
		end else begin
			is_read          = (op != "wr");
			io_address       = addr;
			io_datasize      = size;
			io_writedata.raw = wdata;
			io_read          = is_read;
			io_write         = !is_read;
			next_edge();
			check_hex("dev_sel", dev_sel, exp_dev);
			check_hex("dev_address", dev_address, addr);
			check_hex("dev_read", dev_read, is_read);
			check_hex("dev_write", dev_write, !is_read);
			check_hex("dev_writedata", dev_writedata.raw, wdata);
			check_hex("ide0_read", ide0_read, is_read && exp_dev == 4'd1);
			check_hex("ide1_read", ide1_read, is_read && exp_dev == 4'd2);
			io_read  = (op == "rh"); // kept up while io_wait is high.
			io_write = 1'b0;
			next_edge();
			if (is_read) begin
				check_hex("io_readdata", io_readdata, exp_rdata);
				check_hex("io_io32", io_io32, exp_io32);
			end
			if (op == "rh") begin
				wait_for_wait(1'b1);
				if (exp_dev == 4'd1)
					check_hex("ide0_read", ide0_read, 1);
				else
					check_hex("ide1_read", ide1_read, 1);
			end else begin
				check_hex("io_wait", io_wait, 0);
			end
		end
		check_hex("syscfg", syscfg, exp_cfg);
	endtask

	initial begin
		int          fd;
		int          n;
		string       line;
		string       op;
		logic [15:0] addr;
		logic [2:0]  size;
		logic [31:0] wdata;
		logic [3:0]  exp_dev;
		logic [31:0] exp_rdata;
		logic        exp_io32;
		logic [7:0]  exp_cfg;
		reset            = 1'b1;
		io_address       = '0;
		io_read          = 1'b0;
		io_write         = 1'b0;
		io_datasize      = 3'd0;
		io_writedata.raw = 32'd0;
		ide0_nodata      = 1'b0;
		ide1_nodata      = 1'b0;
		repeat (5) next_edge();
		reset = 1'b0;
		fd = $fopen("tests/system_io_tests.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open tests/system_io_tests.txt");
		end else begin
			while (!$feof(fd) && !aborted) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() < 2 || line[0] == "#")
					continue;
				n = $sscanf(line, "%s %h %h %h %h %h %h %h", op, addr, size, wdata,
					exp_dev, exp_rdata, exp_io32, exp_cfg);
				if (n != 8) begin
					errors++;
					$display("malformed test line: %s", line);
				end else begin
					run_op(op, addr, size, wdata, exp_dev, exp_rdata, exp_io32, exp_cfg);
				end
			end
			$fclose(fd);
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* tests/system_io_tests.txt */
# op addr size wdata exp_dev exp_rdata exp_io32 exp_cfg, all hex
# ops: id idle, rd read, rh read held by io_wait, wr write, ns/nc nodata set/clear (addr = channel)
id 0000 0 00000000 0 00000000 0 a2
rd 0000 0 00000000 4 00000014 0 a2
rd 0010 0 00000000 0 000000ff 0 a2
rd 0021 0 00000000 5 00000015 0 a2
rd 0043 0 00000000 6 00000016 0 a2
rd 0044 0 00000000 0 000000ff 0 a2
rd 0061 0 00000000 6 00000016 0 a2
rd 0067 0 00000000 7 00000017 0 a2
rd 0071 0 00000000 8 00000018 0 a2
rd 009f 0 00000000 7 00000017 0 a2
rd 00e0 0 00000000 0 000000ff 0 a2
rd 0201 0 00000000 e 0000001e 0 a2
rd 022f 0 00000000 9 00000019 0 a2
rd 02ff 0 00000000 b 0000001b 0 a2
rd 0331 0 00000000 c 0000001c 0 a2
rd 03df 0 00000000 d 0000001d 0 a2
rd 03ff 0 00000000 a 0000001a 0 a2
rd 03f0 0 00000000 3 00000013 0 00
wr 8888 2 0000a155 f 00000000 0 55
wr 8888 2 0000b266 f 00000000 0 55
wr 8888 1 0000a177 f 00000000 0 55
rd 01f7 0 00000000 1 a0b1c2d3 1 55
rd 03f6 0 00000000 1 a0b1c2d3 0 55
rd 0170 0 00000000 2 5e6f7081 1 55
rd 0178 0 00000000 0 000000ff 0 55
ns 0000 0 00000000 0 00000000 0 55
rd 01f1 0 00000000 1 a0b1c2d3 1 55
rh 01f0 0 00000000 1 a0b1c2d3 1 55
nc 0000 0 00000000 0 00000000 0 55
id 0000 0 00000000 0 00000000 0 55

/* project.f */
src/io_pkg.sv
src/port_decode.sv
src/read_return.sv
src/ide_read_hold.sv
src/sysctl_port.sv
src/system_io.sv
tests/system_io_sva.sv
tests/tb_system_io.sv

/* Bender.yml */
package:
  name: system_io

sources:
  - src/io_pkg.sv
  - src/port_decode.sv
  - src/read_return.sv
  - src/ide_read_hold.sv
  - src/sysctl_port.sv
  - src/system_io.sv
  - target: test
    files:
      - tests/system_io_sva.sv
      - tests/tb_system_io.sv
